/* rtl/routerPkg.sv */
package routerPkg;

  localparam int NumPorts  = 5;
  localparam int LenWidth  = 12;
  localparam int DataWidth = 32;

  // **************************************************
  // Flit format.
  // **************************************************

  // Head flit is encoded as 1.
  typedef enum logic [1:0] {
    flitHead = 2'd1,
    flitBody = 2'd2,
    flitTail = 2'd3
  } flitKindE;

  // Order here is the rotation order.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portE;

  // Length is only valid in a head flit and counts clock cycles of grant.
  typedef struct packed {
    flitKindE               kind;
    logic [LenWidth-1:0]    length;
    logic [DataWidth-1:0]   data;
  } flitT;

  typedef struct packed {
    portE src;
    flitT flit;
  } outFlitT;

  typedef enum logic {
    arbIdle  = 1'b0,
    arbGrant = 1'b1
  } arbStateE;

endpackage

/* rtl/flitFifo.sv */
`timescale 1ns/1ps

module flitFifo #(
  parameter int FifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT inFlit,
  input  logic            inValid,
  output logic            inReady,
  output routerPkg::flitT bufFlit,
  output logic            bufValid,
  input  logic            bufPop
);

  import routerPkg::*;

  localparam int PtrWidth   = $clog2(FifoDepth);
  localparam int CountWidth = $clog2(FifoDepth + 1);

  flitT                  mem [FifoDepth];
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;
  logic                  full;
  logic                  doWrite;
  logic                  doRead;

  // Depth need not be a power of two.
  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CountWidth'(FifoDepth));
  assign bufValid = (count != '0);
  assign bufFlit  = mem[rdPtr];

  // A pop frees a slot in the same cycle.
  assign inReady  = !full || bufPop;
  assign doWrite  = inValid && inReady;
  assign doRead   = bufPop && bufValid;

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doRead)
        rdPtr <= nextPtr(rdPtr);
      if (doWrite && !doRead)
        count <= count + 1'b1;
      else if (doRead && !doWrite)
        count <= count - 1'b1;
    end
  end

endmodule

/* rtl/grantTimer.sv */
`timescale 1ns/1ps

module grantTimer (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT headFlit,
  input  logic            headValid,
  input  logic            owned,
  output logic            expired
);

  import routerPkg::*;

  logic [LenWidth-1:0] budget;
  logic [LenWidth-1:0] count;

  // Budget survives the loss of a grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
    end
    else if (headValid && headFlit.kind == flitHead)
    begin
      budget <= headFlit.length;
    end
  end

  // Counts owned cycles only.
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (owned)
      count <= count + 1'b1;
    else
      count <= '0;
  end

  assign expired = (count == budget);

endmodule

/* rtl/outputArbiter.sv */
`timescale 1ns/1ps

module outputArbiter (
  input  logic                                     clk,
  input  logic                                     rst,
  input  routerPkg::flitT [routerPkg::NumPorts-1:0] bufFlit,
  input  logic [routerPkg::NumPorts-1:0]            bufValid,
  output logic                                     grantValid,
  output routerPkg::portE                          grantPort
);

  import routerPkg::*;

  arbStateE              state;
  arbStateE              stateNext;
  portE                  owner;
  portE                  ownerNext;
  logic [NumPorts-1:0]   owned;
  logic [NumPorts-1:0]   expired;

  // **************************************************
  // Per-port grant budget.
  // **************************************************

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    assign owned[p] = grantValid && (grantPort == portE'(p));

    grantTimer uTimer (
      .clk       (clk),
      .rst       (rst),
      .headFlit  (bufFlit[p]),
      .headValid (bufValid[p]),
      .owned     (owned[p]),
      .expired   (expired[p])
    );
  end

  // **************************************************
  // Rotation search and next state.
  // **************************************************

  always_comb
  begin
    int   first;
    int   tries;
    logic [2:0] idx;
    logic found;
    portE pick;

    // Idle searches all ports from Local.
    // Grant searches the others, starting after the owner.
    if (state == arbGrant)
    begin
      first = int'(owner) + 1;
      tries = NumPorts - 1;
    end
    else
    begin
      first = 0;
      tries = NumPorts;
    end

    found = 1'b0;
    pick  = owner;
    for (int i = 0; i < NumPorts; i++)
    begin
      idx = 3'((first + i) % NumPorts);
      if (!found && i < tries && bufValid[idx])
      begin
        found = 1'b1;
        pick  = portE'(idx);
      end
    end

    stateNext = state;
    ownerNext = owner;
    if (state == arbGrant && bufValid[owner] && !expired[owner])
    begin
      stateNext = arbGrant;
    end
    else if (found)
    begin
      stateNext = arbGrant;
      ownerNext = pick;
    end
    else
    begin
      stateNext = arbIdle;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
      owner <= portLocal;
    end
    else
    begin
      state <= stateNext;
      owner <= ownerNext;
    end
  end

  assign grantValid = (state == arbGrant);
  assign grantPort  = owner;

endmodule

/* rtl/outputStage.sv */
`timescale 1ns/1ps

module outputStage (
  input  logic                                     clk,
  input  logic                                     rst,
  input  routerPkg::flitT [routerPkg::NumPorts-1:0] bufFlit,
  input  logic [routerPkg::NumPorts-1:0]            bufValid,
  output logic [routerPkg::NumPorts-1:0]            bufPop,
  input  logic                                     grantValid,
  input  routerPkg::portE                          grantPort,
  output routerPkg::outFlitT                       outFlit,
  output logic                                     outValid,
  input  logic                                     outReady
);

  import routerPkg::*;

  logic canLoad;
  logic popAny;
  flitT selFlit;

  // Register is free when empty or drained this cycle.
  assign canLoad = !outValid || outReady;
  assign selFlit = bufFlit[grantPort];

  always_comb
  begin
    bufPop = '0;
    if (grantValid && bufValid[grantPort] && canLoad)
      bufPop[grantPort] = 1'b1;
  end

  assign popAny = |bufPop;

  // Tag with the source so interleaved packets can be sorted out downstream.
  always_ff @(posedge clk)
  begin
    if (popAny)
    begin
      outFlit.src  <= grantPort;
      outFlit.flit <= selFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (popAny)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

endmodule

/* rtl/routerOutput.sv */
`timescale 1ns/1ps

module routerOutput #(
  parameter int FifoDepth = 4
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  routerPkg::flitT [routerPkg::NumPorts-1:0] inFlit,
  input  logic [routerPkg::NumPorts-1:0]            inValid,
  output logic [routerPkg::NumPorts-1:0]            inReady,
  output routerPkg::outFlitT                       outFlit,
  output logic                                     outValid,
  input  logic                                     outReady
);

  import routerPkg::*;

  flitT [NumPorts-1:0] bufFlit;
  logic [NumPorts-1:0] bufValid;
  logic [NumPorts-1:0] bufPop;
  logic                grantValid;
  portE                grantPort;

  // One buffer per input, in rotation order.
  for (genvar p = 0; p < NumPorts; p++)
  begin : gInput
    flitFifo #(
      .FifoDepth (FifoDepth)
    ) uFifo (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[p]),
      .inValid  (inValid[p]),
      .inReady  (inReady[p]),
      .bufFlit  (bufFlit[p]),
      .bufValid (bufValid[p]),
      .bufPop   (bufPop[p])
    );
  end

  outputArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .bufFlit    (bufFlit),
    .bufValid   (bufValid),
    .grantValid (grantValid),
    .grantPort  (grantPort)
  );

  outputStage uStage (
    .clk        (clk),
    .rst        (rst),
    .bufFlit    (bufFlit),
    .bufValid   (bufValid),
    .bufPop     (bufPop),
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .outReady   (outReady)
  );

endmodule

/* sim/tbPackets.svh */
`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

// Each packet row holds test, port, flit count, head length, start cycle and gap.
typedef struct packed {
  int test;
  int port;
  int flits;
  int length;
  int start;
  int gap;
} pktT;

// Each test row holds back-pressure, whole order, first flit latency and least switches.
typedef struct packed {
  int backPressure;
  int whole;
  int latency;
  int minSwitches;
} testT;

localparam int NumTests = 5;
localparam int NumPkts  = 24;

localparam testT TestTable [NumTests] = '{
  '{0, 0, 3, 0},
  '{0, 1, 0, 0},
  '{0, 1, 0, 0},
  '{0, 0, 0, 2},
  '{1, 0, 0, 0}
};

// Rows of a whole-order test are listed in the expected output order.
localparam pktT PktTable [NumPkts] = '{
  // Single flow on North.
  '{0, 1, 3, 3, 0, 0},
  '{0, 1, 4, 2, 0, 1},
  // Rotation from idle.
  '{1, 0, 3, 4, 0, 0},
  '{1, 1, 3, 4, 0, 0},
  '{1, 2, 3, 4, 0, 0},
  '{1, 3, 3, 4, 0, 0},
  '{1, 4, 3, 4, 0, 0},
  // East owns first and the rest queue behind it.
  '{2, 2, 3, 4, 0, 0},
  '{2, 3, 3, 4, 2, 0},
  '{2, 4, 3, 4, 2, 0},
  '{2, 0, 3, 4, 2, 0},
  '{2, 1, 3, 4, 2, 0},
  // Local packet with a short budget ahead of North.
  '{3, 0, 4, 1, 0, 0},
  '{3, 1, 3, 8, 0, 0},
  // Mixed traffic.
  '{4, 0, 3, 2, 0, 0},
  '{4, 0, 2, 5, 3, 1},
  '{4, 1, 4, 3, 1, 0},
  '{4, 1, 2, 2, 0, 2},
  '{4, 2, 2, 6, 2, 1},
  '{4, 2, 3, 1, 0, 0},
  '{4, 3, 3, 3, 0, 0},
  '{4, 3, 4, 2, 5, 0},
  '{4, 4, 2, 4, 4, 0},
  '{4, 4, 3, 3, 0, 1}
};

`endif

/* sim/tbRouterOutput.sv */
`timescale 1ns/1ps

module tbRouterOutput;

  import routerPkg::*;

  `include "tbPackets.svh"

  logic                clk;
  logic                rst;
  flitT [NumPorts-1:0] inFlit;
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] inReady;
  outFlitT             outFlit;
  logic                outValid;
  logic                outReady;

  int          cycle;
  int          testStart;
  int          curTest;
  int          errors;
  int          checks;
  int          received;
  int          expectedCount;
  int          firstOutCycle;
  int          switches;
  logic        haveLast;
  portE        lastSrc;
  logic        backPressure;
  logic [31:0] lfsr;
  outFlitT     expBySrc [NumPorts][$];
  outFlitT     expInOrder [$];

  routerOutput #(
    .FifoDepth (4)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  initial
  begin
    clk   = 1'b0;
    cycle = 0;
    forever
    begin
      #4 clk = 1'b1;
      cycle++;
      #4 clk = 1'b0;
    end
  end

  // **************************************************
  // Helpers.
  // **************************************************

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Data holds the table row and the flit index.
  function automatic flitT makeFlit(input int k, input int i);
    flitT f;
    f.kind   = flitBody;
    f.length = '0;
    if (i == 0)
    begin
      f.kind   = flitHead;
      f.length = LenWidth'(PktTable[k].length);
    end
    else if (i == PktTable[k].flits - 1)
    begin
      f.kind = flitTail;
    end
    f.data = {16'(k), 16'(i)};
    return f;
  endfunction

  function automatic int totalFlits();
    int n;
    n = 0;
    for (int k = 0; k < NumPkts; k++)
      n += PktTable[k].flits;
    return n;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportError(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic recordOutput(input outFlitT obs);
    outFlitT exp;
    int      src;
    src = int'(obs.src);
    received++;
    if (firstOutCycle < 0)
      firstOutCycle = cycle;
    if (haveLast && obs.src != lastSrc)
      switches++;
    haveLast = 1'b1;
    lastSrc  = obs.src;
    if (src >= NumPorts)
    begin
      reportError($sformatf("output flit carries unknown source %0d", src));
    end
    else if (TestTable[curTest].whole != 0)
    begin
      if (expInOrder.size() == 0)
      begin
        reportError("output flit arrived after the whole expected sequence");
      end
      else
      begin
        exp = expInOrder.pop_front();
        checkValue("outFlit", 64'(obs), 64'(exp));
      end
    end
    else if (expBySrc[src].size() == 0)
    begin
      reportError($sformatf("extra output flit from port %0d", src));
    end
    else
    begin
      exp = expBySrc[src].pop_front();
      checkValue("outFlit.flit", 64'(obs.flit), 64'(exp.flit));
    end
  endtask

  // **************************************************
  // Drivers and monitor.
  // **************************************************

  task automatic sendPacket(input int p, input int k);
    for (int i = 0; i < PktTable[k].flits; i++)
    begin
      inFlit[p]  = makeFlit(k, i);
      inValid[p] = 1'b1;
      @(negedge clk);
      while (!inReady[p])
        @(negedge clk);
      @(posedge clk);
      #1;
      inValid[p] = 1'b0;
      if (i < PktTable[k].flits - 1)
        repeat (PktTable[k].gap)
        begin
          @(posedge clk);
          #1;
        end
    end
  endtask

  task automatic drivePort(input int p, input int t);
    for (int k = 0; k < NumPkts; k++)
    begin
      if (PktTable[k].test == t && PktTable[k].port == p)
      begin
        while (cycle - testStart < PktTable[k].start)
        begin
          @(posedge clk);
          #1;
        end
        sendPacket(p, k);
      end
    end
  endtask

  initial
  begin : readyDriver
    logic a;
    logic b;
    outReady = 1'b1;
    lfsr     = 32'ha160;
    forever
    begin
      @(posedge clk);
      #1;
      if (backPressure)
      begin
        lfsr     = lfsrStep(lfsr);
        a        = lfsr[0];
        lfsr     = lfsrStep(lfsr);
        b        = lfsr[0];
        outReady = a | b;
      end
      else
      begin
        outReady = 1'b1;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(negedge clk);
      if (!rst && outValid && outReady)
        recordOutput(outFlit);
    end
  end

  initial
  begin
    repeat (20 * totalFlits() + 200) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", 20 * totalFlits() + 200);
    $display("errors: %0d  checks: %0d", errors, checks);
    $display("SIMULATION FAILED");
    $finish;
  end

  // **************************************************
  // Test sequence.
  // **************************************************

  task automatic prepareTest(input int t);
    outFlitT f;
    for (int p = 0; p < NumPorts; p++)
      expBySrc[p].delete();
    expInOrder.delete();
    expectedCount = 0;
    received      = 0;
    firstOutCycle = -1;
    switches      = 0;
    haveLast      = 1'b0;
    curTest       = t;
    for (int k = 0; k < NumPkts; k++)
    begin
      if (PktTable[k].test == t)
      begin
        for (int i = 0; i < PktTable[k].flits; i++)
        begin
          f.src  = portE'(PktTable[k].port);
          f.flit = makeFlit(k, i);
          expBySrc[PktTable[k].port].push_back(f);
          expInOrder.push_back(f);
          expectedCount++;
        end
      end
    end
  endtask

  task automatic finishTest(input int t);
    while (received < expectedCount)
      @(posedge clk);
    // Quiet cycles catch duplicated flits.
    repeat (6) @(posedge clk);
    if (received != expectedCount)
      reportError($sformatf("test %0d saw %0d flits, %0d sent", t, received, expectedCount));
    if (TestTable[t].latency != 0)
      checkValue("first flit latency", 64'(firstOutCycle - testStart),
                 64'(TestTable[t].latency));
    if (switches < TestTable[t].minSwitches)
      reportError($sformatf("test %0d changed source only %0d times", t, switches));
  endtask

  initial
  begin
    rst          = 1'b1;
    inFlit       = '0;
    inValid      = '0;
    backPressure = 1'b0;
    errors       = 0;
    checks       = 0;
    testStart    = 0;
    lastSrc      = portLocal;
    prepareTest(0);
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkValue("outValid", 64'(outValid), 64'(0));
    checkValue("inReady", 64'(inReady), 64'({NumPorts{1'b1}}));
    @(posedge clk);
    for (int t = 0; t < NumTests; t++)
    begin
      backPressure = (TestTable[t].backPressure != 0);
      prepareTest(t);
      @(posedge clk);
      #1;
      testStart = cycle;
      fork
        drivePort(0, t);
        drivePort(1, t);
        drivePort(2, t);
        drivePort(3, t);
        drivePort(4, t);
      join
      finishTest(t);
    end
    $display("errors: %0d  checks: %0d", errors, checks);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+sim
rtl/routerPkg.sv
rtl/flitFifo.sv
rtl/grantTimer.sv
rtl/outputArbiter.sv
rtl/outputStage.sv
rtl/routerOutput.sv
sim/tbRouterOutput.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbRouterOutput
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
